/* common/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data and address width
`define EXU_XLEN 32

// data ram depth in 32-bit words
`define EXU_DMEM_WORDS 256

`endif

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // compares return 1 or 0
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU
  } alu_op_e;

  // branch kinds
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // memory widths
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // system kinds
  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // funct12 of a PRIV instruction, carried in imm[11:0]
  typedef enum logic [11:0] {
    PRIV_ECALL  = 12'h000,
    PRIV_EBREAK = 12'h001,
    PRIV_MRET   = 12'h302
  } priv_e;

endpackage

`default_nettype wire

/* common/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  typedef enum logic [2:0] {
    IDX_NONE, IDX_MCAUSE, IDX_MEPC, IDX_MTVEC, IDX_MSTATUS
  } csr_idx_e;

  localparam int unsigned MSTATUS_MIE   = 3;
  localparam int unsigned MSTATUS_MPIE  = 7;
  localparam int unsigned CAUSE_ECALL_M = 11;

  // unknown addresses map to IDX_NONE
  function automatic csr_idx_e csr_index(csr_addr_e addr);
    case (addr)
      CSR_MCAUSE:  return IDX_MCAUSE;
      CSR_MEPC:    return IDX_MEPC;
      CSR_MTVEC:   return IDX_MTVEC;
      CSR_MSTATUS: return IDX_MSTATUS;
      default:     return IDX_NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module alu (
  input  wire  logic [`EXU_XLEN-1:0] a_i,
  input  wire  logic [`EXU_XLEN-1:0] b_i,
  input  wire  isa_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0]       res_o
);
  import isa_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      // compares, zero-extended flag
      ALU_SLT:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      ALU_SGE:  res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: res_o = {{(`EXU_XLEN-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module data_ram (
  input  wire  logic                    clk,
  input  wire  logic [`EXU_XLEN-1:0]    addr_i,
  input  wire  logic [`EXU_XLEN-1:0]    wdata_i,
  input  wire  logic [`EXU_XLEN/8-1:0]  be_i,
  input  wire  logic                    ren_i,
  output logic [`EXU_XLEN-1:0]          rdata_o
);
  localparam int AW = $clog2(`EXU_DMEM_WORDS);
  localparam int NB = `EXU_XLEN / 8;

  logic [`EXU_XLEN-1:0] mem [0:`EXU_DMEM_WORDS-1];
  logic [AW-1:0]        idx;

  assign idx = addr_i[AW-1:0];

  // read returns the word as it was before this edge
  always_ff @(posedge clk) begin
    for (int i = 0; i < NB; i++) begin
      if (be_i[i]) begin
        mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end
    if (ren_i) begin
      rdata_o <= mem[idx];
    end
  end

  a_addr_in_range: assert property (
    @(posedge clk) (ren_i || |be_i) |-> (addr_i < `EXU_DMEM_WORDS)
  ) else $error("data_ram access beyond depth, word addr %0h", addr_i);

endmodule

`default_nettype wire

/* exu/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module csr_file (
  input  wire  logic                 clk,
  input  wire  logic                 rst,
  input  wire  csr_pkg::csr_addr_e   raddr_i,
  output logic [`EXU_XLEN-1:0]       rdata_o,
  input  wire  logic                 wen_i,
  input  wire  csr_pkg::csr_idx_e    widx_i,
  input  wire  logic [`EXU_XLEN-1:0] wdata_i,
  input  wire  logic                 ecall_i,
  input  wire  logic                 mret_i,
  input  wire  logic [`EXU_XLEN-1:0] epc_i,
  output logic [`EXU_XLEN-1:0]       mepc_o,
  output logic [`EXU_XLEN-1:0]       mtvec_o
);
  import csr_pkg::*;

  logic [`EXU_XLEN-1:0] mcause;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mstatus;
  csr_idx_e             ridx;

  assign ridx = csr_index(raddr_i);

  always_comb begin
    case (ridx)
      IDX_MCAUSE:  rdata_o = mcause;
      IDX_MEPC:    rdata_o = mepc;
      IDX_MTVEC:   rdata_o = mtvec;
      IDX_MSTATUS: rdata_o = mstatus;
      default:     rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  always_ff @(posedge clk) begin
    if (rst) begin
      mcause  <= '0;
      mepc    <= '0;
      mtvec   <= '0;
      mstatus <= '0;
    end else if (ecall_i) begin
      mepc                  <= epc_i;
      mcause                <= `EXU_XLEN'(CAUSE_ECALL_M);
      mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
      mstatus[MSTATUS_MIE]  <= 1'b0;
    end else if (mret_i) begin
      mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
      mstatus[MSTATUS_MPIE] <= 1'b1;
    end else if (wen_i) begin
      case (widx_i)
        IDX_MCAUSE:  mcause  <= wdata_i;
        IDX_MEPC:    mepc    <= wdata_i;
        IDX_MTVEC:   mtvec   <= wdata_i;
        IDX_MSTATUS: mstatus <= wdata_i;
        default:     begin end
      endcase
    end
  end

  a_priv_onehot: assert property (
    @(posedge clk) disable iff (rst) !(ecall_i && mret_i)
  ) else $error("ecall and mret requested together");

endmodule

`default_nettype wire

/* exu/branch_sys_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module branch_sys_unit (
  input  wire  logic                 clk,
  input  wire  logic                 rst,
  input  wire  logic                 valid_i,
  input  wire  isa_pkg::opcode_e     opcode_i,
  input  wire  logic [2:0]           funct3_i,
  input  wire  isa_pkg::alu_op_e     alu_op_i,
  input  wire  logic [`EXU_XLEN-1:0] op1_i,
  input  wire  logic [`EXU_XLEN-1:0] pc_i,
  input  wire  logic [`EXU_XLEN-1:0] imm_i,
  input  wire  csr_pkg::csr_addr_e   csr_addr_i,
  input  wire  logic [`EXU_XLEN-1:0] alu_res_i,
  output logic                       csr_wen_o,
  output csr_pkg::csr_idx_e          csr_widx_o,
  output logic [`EXU_XLEN-1:0]       csr_wdata_o,
  output logic                       ecall_o,
  output logic                       mret_o,
  input  wire  logic [`EXU_XLEN-1:0] csr_rdata_i,
  input  wire  logic [`EXU_XLEN-1:0] mepc_i,
  input  wire  logic [`EXU_XLEN-1:0] mtvec_i,
  output logic                       valid_o,
  output logic [`EXU_XLEN-1:0]       result_o,
  output logic [`EXU_XLEN-1:0]       npc_o,
  output logic                       ebreak_o
);
  import isa_pkg::*;
  import csr_pkg::*;

  logic [`EXU_XLEN-1:0] pc_plus4;
  logic [`EXU_XLEN-1:0] jump_sum;
  logic [`EXU_XLEN-1:0] target;
  logic [`EXU_XLEN-1:0] result_d;
  logic [`EXU_XLEN-1:0] npc_d;
  logic                 taken;
  logic                 is_priv;
  logic                 is_csr;
  logic                 ebreak_d;
  priv_e                priv_code;

  assign pc_plus4 = pc_i + `EXU_XLEN'(4);
  assign jump_sum = ((opcode_i == OPC_JALR) ? op1_i : pc_i) + imm_i;
  // jalr drops bit 0 of the target
  assign target   = {jump_sum[`EXU_XLEN-1:1], jump_sum[0] & (opcode_i != OPC_JALR)};

  assign priv_code = priv_e'(imm_i[11:0]);
  assign is_priv   = (opcode_i == OPC_SYSTEM) && (funct3_i == F3_PRIV);
  assign is_csr    = (opcode_i == OPC_SYSTEM) && (funct3_i != F3_PRIV);

  // eq/ne test for zero, the rest read the compare flag
  always_comb begin
    case (funct3_i)
      F3_BEQ:  taken = (alu_res_i == '0);
      F3_BNE:  taken = (alu_res_i != '0);
      default: taken = alu_res_i[0];
    endcase
  end

  assign csr_widx_o = csr_index(csr_addr_i);
  assign csr_wen_o  = valid_i && is_csr && (csr_widx_o != IDX_NONE);

  always_comb begin
    case (funct3_i)
      F3_CSRRS, F3_CSRRSI: csr_wdata_o = csr_rdata_i | op1_i;
      F3_CSRRC, F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~op1_i;
      F3_CSRRW, F3_CSRRWI: csr_wdata_o = op1_i;
      default:             csr_wdata_o = op1_i;
    endcase
  end

  assign ecall_o  = valid_i && is_priv && (priv_code == PRIV_ECALL);
  assign mret_o   = valid_i && is_priv && (priv_code == PRIV_MRET);
  assign ebreak_d = valid_i && is_priv && (priv_code == PRIV_EBREAK);

  always_comb begin
    npc_d    = pc_plus4;
    result_d = '0;
    case (opcode_i)
      OPC_OP, OPC_OP_IMM: result_d = alu_res_i;
      OPC_BRANCH: begin
        if (taken) npc_d = target;
      end
      OPC_JAL, OPC_JALR: begin
        npc_d    = target;
        result_d = pc_plus4;
      end
      OPC_SYSTEM: begin
        if (is_csr) result_d = csr_rdata_i;
        else if (priv_code == PRIV_ECALL) npc_d = mtvec_i;
        else if (priv_code == PRIV_MRET) npc_d = mepc_i;
      end
      default: begin end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o  <= 1'b0;
      ebreak_o <= 1'b0;
    end else begin
      valid_o  <= valid_i;
      ebreak_o <= ebreak_d;
    end
  end

  always_ff @(posedge clk) begin
    result_o <= result_d;
    npc_o    <= npc_d;
  end

  // decoder must pair each branch kind with a matching compare
  function automatic logic cmp_matches(logic [2:0] f3, alu_op_e op);
    case (f3)
      F3_BEQ, F3_BNE: return (op == ALU_SUB) || (op == ALU_XOR);
      F3_BLT:         return op == ALU_SLT;
      F3_BGE:         return op == ALU_SGE;
      F3_BLTU:        return op == ALU_SLTU;
      F3_BGEU:        return op == ALU_SGEU;
      default:        return 1'b0;
    endcase
  endfunction

  a_branch_op: assert property (
    @(posedge clk) disable iff (rst)
      (valid_i && opcode_i == OPC_BRANCH) |-> cmp_matches(funct3_i, alu_op_i)
  ) else $error("branch funct3 %0d with alu op %s", funct3_i, alu_op_i.name());

endmodule

`default_nettype wire

/* exu/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module load_store_unit (
  input  wire  logic                    clk,
  input  wire  logic                    rst,
  input  wire  logic                    valid_i,
  input  wire  isa_pkg::opcode_e        opcode_i,
  input  wire  logic [2:0]              funct3_i,
  input  wire  logic [`EXU_XLEN-1:0]    op1_i,
  input  wire  logic [`EXU_XLEN-1:0]    op2_i,
  input  wire  logic [`EXU_XLEN-1:0]    imm_i,
  output logic [`EXU_XLEN-1:0]          ram_addr_o,
  output logic [`EXU_XLEN-1:0]          ram_wdata_o,
  output logic [`EXU_XLEN/8-1:0]        ram_be_o,
  output logic                          ram_ren_o,
  input  wire  logic [`EXU_XLEN-1:0]    ram_rdata_i,
  input  wire  logic [`EXU_XLEN-1:0]    result_i,
  output logic [`EXU_XLEN-1:0]          reg_wdata_o
);
  import isa_pkg::*;

  localparam int NB = `EXU_XLEN / 8;

  logic [`EXU_XLEN-1:0] addr;
  logic [1:0]           off;
  logic [NB-1:0]        be;
  logic                 is_mem;
  logic                 misaligned;
  logic                 load_q;
  logic [2:0]           f3_q;
  logic [1:0]           off_q;
  logic [`EXU_XLEN-1:0] lane;
  logic [`EXU_XLEN-1:0] load_data;

  assign addr   = op1_i + imm_i;
  assign off    = addr[1:0];
  assign is_mem = (opcode_i == OPC_LOAD) || (opcode_i == OPC_STORE);

  always_comb begin
    case (funct3_i[1:0])
      2'b00:   be = {{(NB-1){1'b0}}, 1'b1} << off;
      2'b01:   be = {{(NB-2){1'b0}}, 2'b11} << off;
      default: be = {NB{1'b1}};
    endcase
  end

  // word address into the ram
  assign ram_addr_o  = {2'b00, addr[`EXU_XLEN-1:2]};
  assign ram_wdata_o = op2_i << {off, 3'b000};
  assign ram_be_o    = (valid_i && opcode_i == OPC_STORE) ? be : '0;
  assign ram_ren_o   = valid_i && (opcode_i == OPC_LOAD);

  always_ff @(posedge clk) begin
    if (rst) begin
      load_q <= 1'b0;
    end else begin
      load_q <= ram_ren_o;
    end
  end

  always_ff @(posedge clk) begin
    f3_q  <= funct3_i;
    off_q <= off;
  end

  assign lane = ram_rdata_i >> {off_q, 3'b000};

  always_comb begin
    case (f3_q)
      F3_B:    load_data = {{(`EXU_XLEN-8){lane[7]}}, lane[7:0]};
      F3_BU:   load_data = {{(`EXU_XLEN-8){1'b0}}, lane[7:0]};
      F3_H:    load_data = {{(`EXU_XLEN-16){lane[15]}}, lane[15:0]};
      F3_HU:   load_data = {{(`EXU_XLEN-16){1'b0}}, lane[15:0]};
      F3_W:    load_data = lane;
      default: load_data = lane;
    endcase
  end

  assign reg_wdata_o = load_q ? load_data : result_i;

  assign misaligned = ((funct3_i[1:0] == 2'b01) && off[0]) ||
                      ((funct3_i[1:0] == 2'b10) && (off != 2'b00));

  a_aligned: assert property (
    @(posedge clk) disable iff (rst) (valid_i && is_mem) |-> !misaligned
  ) else $error("misaligned access at %0h, funct3 %0d", addr, funct3_i);

endmodule

`default_nettype wire

/* rtl/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top (
  input  wire  logic                 clk,
  input  wire  logic                 rst,
  input  wire  logic                 valid_i,
  input  wire  isa_pkg::opcode_e     opcode_i,
  input  wire  logic [2:0]           funct3_i,
  input  wire  isa_pkg::alu_op_e     alu_op_i,
  input  wire  logic [`EXU_XLEN-1:0] op1_i,
  input  wire  logic [`EXU_XLEN-1:0] op2_i,
  input  wire  logic [`EXU_XLEN-1:0] pc_i,
  input  wire  logic [`EXU_XLEN-1:0] imm_i,
  input  wire  csr_pkg::csr_addr_e   csr_addr_i,
  output logic                       valid_o,
  output logic [`EXU_XLEN-1:0]       reg_wdata_o,
  output logic [`EXU_XLEN-1:0]       npc_o,
  output logic                       ebreak_o
);
  import csr_pkg::*;

  logic [`EXU_XLEN-1:0]   alu_res;
  logic                   csr_wen;
  csr_idx_e               csr_widx;
  logic [`EXU_XLEN-1:0]   csr_wdata;
  logic                   ecall;
  logic                   mret;
  logic [`EXU_XLEN-1:0]   csr_rdata;
  logic [`EXU_XLEN-1:0]   mepc;
  logic [`EXU_XLEN-1:0]   mtvec;
  logic [`EXU_XLEN-1:0]   result;
  logic [`EXU_XLEN-1:0]   ram_addr;
  logic [`EXU_XLEN-1:0]   ram_wdata;
  logic [`EXU_XLEN/8-1:0] ram_be;
  logic                   ram_ren;
  logic [`EXU_XLEN-1:0]   ram_rdata;

  // op2 already holds the immediate for OP_IMM
  alu alu_main (
    .a_i   (op1_i),
    .b_i   (op2_i),
    .op_i  (alu_op_i),
    .res_o (alu_res)
  );

  csr_file i_csr_file (
    .clk     (clk),
    .rst     (rst),
    .raddr_i (csr_addr_i),
    .rdata_o (csr_rdata),
    .wen_i   (csr_wen),
    .widx_i  (csr_widx),
    .wdata_i (csr_wdata),
    .ecall_i (ecall),
    .mret_i  (mret),
    .epc_i   (pc_i),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  branch_sys_unit i_branch_sys_unit (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (valid_i),
    .opcode_i    (opcode_i),
    .funct3_i    (funct3_i),
    .alu_op_i    (alu_op_i),
    .op1_i       (op1_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .csr_addr_i  (csr_addr_i),
    .alu_res_i   (alu_res),
    .csr_wen_o   (csr_wen),
    .csr_widx_o  (csr_widx),
    .csr_wdata_o (csr_wdata),
    .ecall_o     (ecall),
    .mret_o      (mret),
    .csr_rdata_i (csr_rdata),
    .mepc_i      (mepc),
    .mtvec_i     (mtvec),
    .valid_o     (valid_o),
    .result_o    (result),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o)
  );

  load_store_unit i_load_store_unit (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (valid_i),
    .opcode_i    (opcode_i),
    .funct3_i    (funct3_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .imm_i       (imm_i),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be),
    .ram_ren_o   (ram_ren),
    .ram_rdata_i (ram_rdata),
    .result_i    (result),
    .reg_wdata_o (reg_wdata_o)
  );

  data_ram i_data_ram (
    .clk     (clk),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .be_i    (ram_be),
    .ren_i   (ram_ren),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

/* tests/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_tb;
  import isa_pkg::*;
  import csr_pkg::*;

  localparam int XLEN      = `EXU_XLEN;
  localparam int RAM_BYTES = `EXU_DMEM_WORDS * 4;

  typedef struct packed {
    logic            valid;
    logic            ebreak;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] npc;
  } exp_t;

  logic            clk;
  logic            rst;
  logic            valid_i;
  opcode_e         opcode_i;
  logic [2:0]      funct3_i;
  alu_op_e         alu_op_i;
  logic [XLEN-1:0] op1_i;
  logic [XLEN-1:0] op2_i;
  logic [XLEN-1:0] pc_i;
  logic [XLEN-1:0] imm_i;
  csr_addr_e       csr_addr_i;
  logic            valid_o;
  logic [XLEN-1:0] reg_wdata_o;
  logic [XLEN-1:0] npc_o;
  logic            ebreak_o;

  // reference state
  logic [7:0]      ram_m [0:RAM_BYTES-1];
  logic [XLEN-1:0] m_mcause;
  logic [XLEN-1:0] m_mepc;
  logic [XLEN-1:0] m_mtvec;
  logic [XLEN-1:0] m_mstatus;
  exp_t            exp_q[$];
  int              checks;
  int unsigned     seed_ret;

  exu_top i_exu_top (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (valid_i),
    .opcode_i    (opcode_i),
    .funct3_i    (funct3_i),
    .alu_op_i    (alu_op_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .csr_addr_i  (csr_addr_i),
    .valid_o     (valid_o),
    .reg_wdata_o (reg_wdata_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    report_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  function automatic logic [XLEN-1:0] sext12(input logic [31:0] v);
    return {{(XLEN-12){v[11]}}, v[11:0]};
  endfunction

  function automatic logic [XLEN-1:0] rand_pc();
    return $urandom & 32'hffff_fffc;
  endfunction

  // whole-address fill pattern for the ram
  function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_SLT:  return XLEN'($signed(a) < $signed(b));
      ALU_SLTU: return XLEN'(a < b);
      ALU_SGE:  return XLEN'($signed(a) >= $signed(b));
      ALU_SGEU: return XLEN'(a >= b);
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_read(input csr_addr_e addr);
    case (addr)
      CSR_MCAUSE:  return m_mcause;
      CSR_MEPC:    return m_mepc;
      CSR_MTVEC:   return m_mtvec;
      CSR_MSTATUS: return m_mstatus;
      default:     return '0;
    endcase
  endfunction

  task automatic csr_write(input csr_addr_e addr, input logic [XLEN-1:0] val);
    case (addr)
      CSR_MCAUSE:  m_mcause = val;
      CSR_MEPC:    m_mepc = val;
      CSR_MTVEC:   m_mtvec = val;
      CSR_MSTATUS: m_mstatus = val;
      default:     begin end
    endcase
  endtask

  function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] addr,
                                                 input logic [2:0] f3);
    int a;
    a = int'(addr & (RAM_BYTES - 1));
    case (f3)
      F3_B:    return {{(XLEN-8){ram_m[a][7]}}, ram_m[a]};
      F3_BU:   return {{(XLEN-8){1'b0}}, ram_m[a]};
      F3_H:    return {{(XLEN-16){ram_m[a+1][7]}}, ram_m[a+1], ram_m[a]};
      F3_HU:   return {{(XLEN-16){1'b0}}, ram_m[a+1], ram_m[a]};
      default: return {ram_m[a+3], ram_m[a+2], ram_m[a+1], ram_m[a]};
    endcase
  endfunction

  task automatic store_bytes(input logic [XLEN-1:0] addr, input logic [2:0] f3,
                             input logic [XLEN-1:0] data);
    int a;
    int n;
    a = int'(addr & (RAM_BYTES - 1));
    n = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      ram_m[a+i] = data[8*i +: 8];
    end
  endtask

  // reference execution updates the model state
  task automatic predict(input opcode_e opc, input logic [2:0] f3, input alu_op_e aop,
                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
                         input csr_addr_e caddr, output exp_t e);
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] nv;
    e.valid  = 1'b1;
    e.ebreak = 1'b0;
    e.wdata  = '0;
    e.npc    = pc + 4;
    case (opc)
      OPC_OP, OPC_OP_IMM: e.wdata = ref_alu(aop, a, b);
      OPC_BRANCH: begin
        if (branch_taken(f3, a, b)) e.npc = pc + imm;
      end
      OPC_JAL: begin
        e.npc   = pc + imm;
        e.wdata = pc + 4;
      end
      OPC_JALR: begin
        sum     = a + imm;
        e.npc   = {sum[XLEN-1:1], 1'b0};
        e.wdata = pc + 4;
      end
      OPC_STORE: store_bytes(a + imm, f3, b);
      OPC_LOAD:  e.wdata = load_value(a + imm, f3);
      default: begin
        if (f3 == F3_PRIV) begin
          case (imm[11:0])
            PRIV_ECALL: begin
              e.npc     = m_mtvec;
              m_mepc    = pc;
              m_mcause  = XLEN'(CAUSE_ECALL_M);
              m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
              m_mstatus[MSTATUS_MIE]  = 1'b0;
            end
            PRIV_MRET: begin
              e.npc = m_mepc;
              m_mstatus[MSTATUS_MIE]  = m_mstatus[MSTATUS_MPIE];
              m_mstatus[MSTATUS_MPIE] = 1'b1;
            end
            default: e.ebreak = 1'b1;
          endcase
        end else begin
          old     = csr_read(caddr);
          e.wdata = old;
          case (f3)
            F3_CSRRW, F3_CSRRWI: nv = a;
            F3_CSRRS, F3_CSRRSI: nv = old | a;
            default:             nv = old & ~a;
          endcase
          csr_write(caddr, nv);
        end
      end
    endcase
  endtask

  // compares the instruction sampled at the last rising edge
  task automatic check_previous();
    exp_t e;
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      checks++;
      assert (valid_o === e.valid) else report_mismatch("valid_o", valid_o, e.valid);
      assert (ebreak_o === e.ebreak) else report_mismatch("ebreak_o", ebreak_o, e.ebreak);
      if (e.valid) begin
        assert (reg_wdata_o === e.wdata) else report_mismatch("reg_wdata_o", reg_wdata_o, e.wdata);
        assert (npc_o === e.npc) else report_mismatch("npc_o", npc_o, e.npc);
      end
    end
  endtask

  task automatic issue(input opcode_e opc, input logic [2:0] f3, input alu_op_e aop,
                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                       input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
                       input csr_addr_e caddr);
    exp_t e;
    @(posedge clk);
    valid_i    <= 1'b1;
    opcode_i   <= opc;
    funct3_i   <= f3;
    alu_op_i   <= aop;
    op1_i      <= a;
    op2_i      <= b;
    pc_i       <= pc;
    imm_i      <= imm;
    csr_addr_i <= caddr;
    @(negedge clk);
    check_previous();
    predict(opc, f3, aop, a, b, pc, imm, caddr, e);
    exp_q.push_back(e);
  endtask

  task automatic idle();
    exp_t e;
    @(posedge clk);
    valid_i <= 1'b0;
    op1_i   <= $urandom;
    @(negedge clk);
    check_previous();
    e = '0;
    exp_q.push_back(e);
  endtask

  task automatic rand_alu();
    logic            imm_form;
    alu_op_e         aop;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    imm_form = ($urandom_range(0, 1) == 1);
    aop      = alu_op_e'(4'($urandom_range(0, 11)));
    a        = $urandom;
    b        = imm_form ? sext12($urandom) : $urandom;
    if ($urandom_range(0, 7) == 0) b = a;
    // register form carries an unrelated immediate
    imm      = imm_form ? b : sext12($urandom);
    issue(imm_form ? OPC_OP_IMM : OPC_OP, 3'b000, aop, a, b, rand_pc(), imm, CSR_MSTATUS);
  endtask

  task automatic rand_branch();
    opcode_e         opc;
    logic [2:0]      f3;
    alu_op_e         aop;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    a      = $urandom;
    b      = ($urandom_range(0, 2) == 0) ? a : $urandom;
    imm    = sext12($urandom);
    imm[0] = 1'b0;
    opc    = OPC_BRANCH;
    f3     = 3'b000;
    aop    = ALU_ADD;
    case ($urandom_range(0, 7))
      0: begin
        f3  = F3_BEQ;
        aop = ALU_SUB;
      end
      1: begin
        f3  = F3_BNE;
        aop = ALU_XOR;
      end
      2: begin
        f3  = F3_BLT;
        aop = ALU_SLT;
      end
      3: begin
        f3  = F3_BGE;
        aop = ALU_SGE;
      end
      4: begin
        f3  = F3_BLTU;
        aop = ALU_SLTU;
      end
      5: begin
        f3  = F3_BGEU;
        aop = ALU_SGEU;
      end
      6: opc = OPC_JAL;
      // odd offsets exercise the cleared low bit
      default: begin
        opc = OPC_JALR;
        imm = sext12($urandom);
      end
    endcase
    issue(opc, f3, aop, a, b, rand_pc(), imm, CSR_MSTATUS);
  endtask

  task automatic rand_mem(input logic is_store);
    int              w;
    int              off;
    logic [2:0]      f3;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] imm;
    w = $urandom_range(0, 2);
    case (w)
      0:       off = $urandom_range(0, 3);
      1:       off = 2 * $urandom_range(0, 1);
      default: off = 0;
    endcase
    addr = XLEN'($urandom_range(0, `EXU_DMEM_WORDS - 1) * 4 + off);
    f3   = 3'(w);
    if (!is_store && w < 2 && $urandom_range(0, 1) == 1) f3[2] = 1'b1;
    imm = sext12($urandom);
    issue(is_store ? OPC_STORE : OPC_LOAD, f3, ALU_ADD, addr - imm, $urandom, rand_pc(), imm,
          CSR_MSTATUS);
  endtask

  task automatic csr_op(input logic [2:0] f3, input csr_addr_e caddr,
                        input logic [XLEN-1:0] a);
    issue(OPC_SYSTEM, f3, ALU_ADD, a, '0, rand_pc(), XLEN'(caddr), caddr);
  endtask

  task automatic rand_csr();
    logic [2:0] f3;
    csr_addr_e  caddr;
    case ($urandom_range(0, 5))
      0:       f3 = F3_CSRRW;
      1:       f3 = F3_CSRRS;
      2:       f3 = F3_CSRRC;
      3:       f3 = F3_CSRRWI;
      4:       f3 = F3_CSRRSI;
      default: f3 = F3_CSRRCI;
    endcase
    case ($urandom_range(0, 4))
      0:       caddr = CSR_MCAUSE;
      1:       caddr = CSR_MEPC;
      2:       caddr = CSR_MTVEC;
      3:       caddr = CSR_MSTATUS;
      default: caddr = csr_addr_e'(12'h7c0);
    endcase
    csr_op(f3, caddr, f3[2] ? XLEN'($urandom_range(0, 31)) : XLEN'($urandom));
  endtask

  task automatic issue_priv(input priv_e code);
    issue(OPC_SYSTEM, F3_PRIV, ALU_ADD, $urandom, $urandom, rand_pc(), XLEN'(code),
          CSR_MSTATUS);
  endtask

  task automatic trap_round_trip();
    csr_op(F3_CSRRW, CSR_MTVEC, rand_pc());
    csr_op(F3_CSRRSI, CSR_MSTATUS, XLEN'(1) << MSTATUS_MIE);
    issue_priv(PRIV_ECALL);
    csr_op(F3_CSRRS, CSR_MEPC, '0);
    csr_op(F3_CSRRS, CSR_MCAUSE, '0);
    csr_op(F3_CSRRS, CSR_MSTATUS, '0);
    issue_priv(PRIV_MRET);
    csr_op(F3_CSRRS, CSR_MSTATUS, '0);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((valid_o !== 1'b0 || ebreak_o !== 1'b0) && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (valid_o !== 1'b0 || ebreak_o !== 1'b0) begin
      report_failure("valid_o or ebreak_o did not clear after reset");
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 8) begin
      @(posedge clk);
      valid_i <= 1'b0;
      @(negedge clk);
      check_previous();
      waited++;
    end
    if (exp_q.size() > 0) begin
      report_failure("last results never drained from the pipeline");
    end
  endtask

  initial begin
    seed_ret   = $urandom(32'h747a);
    clk        = 1'b0;
    rst        = 1'b1;
    valid_i    = 1'b0;
    opcode_i   = OPC_OP;
    funct3_i   = 3'b000;
    alu_op_i   = ALU_ADD;
    op1_i      = '0;
    op2_i      = '0;
    pc_i       = '0;
    imm_i      = '0;
    csr_addr_i = CSR_MSTATUS;
    m_mcause   = '0;
    m_mepc     = '0;
    m_mtvec    = '0;
    m_mstatus  = '0;
    checks     = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait_reset_release();

    // every ram word gets a known value first
    for (int i = 0; i < `EXU_DMEM_WORDS; i++) begin
      issue(OPC_STORE, F3_W, ALU_ADD, XLEN'(i * 4), fill_word(XLEN'(i * 4)), rand_pc(), '0,
            CSR_MSTATUS);
    end
    repeat (200) rand_alu();
    repeat (200) rand_branch();
    repeat (300) rand_mem($urandom_range(0, 1) == 1);
    repeat (200) rand_csr();
    repeat (2) trap_round_trip();
    issue_priv(PRIV_EBREAK);
    repeat (3) idle();

    // mixed stream with idle gaps
    for (int i = 0; i < 1500; i++) begin
      case ($urandom_range(0, 9))
        0, 1:    rand_alu();
        2, 3:    rand_branch();
        4:       rand_mem(1'b1);
        5:       rand_mem(1'b0);
        6, 7:    rand_csr();
        8:       idle();
        default: begin
          case ($urandom_range(0, 2))
            0:       issue_priv(PRIV_ECALL);
            1:       issue_priv(PRIV_MRET);
            default: issue_priv(PRIV_EBREAK);
          endcase
        end
      endcase
    end
    drain();

    if (checks > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_failure("no results were checked");
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/isa_pkg.sv
common/csr_pkg.sv
rtl/alu.sv
rtl/data_ram.sv
exu/csr_file.sv
exu/branch_sys_unit.sv
exu/load_store_unit.sv
rtl/exu_top.sv
tests/exu_tb.sv
